/* bus_pkg.sv */
/*
 * shared bus definitions for the backplane core
 * widths, address map, device bases and the bus owner encoding
 */
package bus_pkg;

   // bus widths
   localparam int ADDR_W   = 16;
   localparam int DATA_W   = 16;
   localparam int SEL_W    = 2;
   localparam int SDRAM_AW = 15;         // word address, byte address >> 1
   localparam int ROM_AW   = 12;         // 4k words of user rom

   //************************************************************************
   // address map
   //************************************************************************
   localparam logic [ADDR_W-1:0] ROM_BASE     = 16'o140000;  // rom 140000-157777
   localparam logic [ADDR_W-1:0] IO_PAGE_BASE = 16'o160000;  // never ram or rom above

   // device bases in the i/o page
   localparam logic [ADDR_W-1:0] UART_BASE = 16'o177560;     // console tt
   localparam logic [ADDR_W-1:0] LPT_BASE  = 16'o177514;     // printer
   localparam logic [ADDR_W-1:0] RK_BASE   = 16'o177400;     // rk11 disk
   localparam logic [ADDR_W-1:0] DW_BASE   = 16'o174000;     // dw hard disk
   localparam logic [ADDR_W-1:0] MY_BASE   = 16'o172140;     // my floppy

   // low address bits ignored per device
   localparam int UART_SPAN = 3;
   localparam int LPT_SPAN  = 2;
   localparam int RK_SPAN   = 4;
   localparam int DW_SPAN   = 5;
   localparam int MY_SPAN   = 2;

   // ram ack lags the sdram ack by this many clocks
   localparam int ACK_DELAY = 2;

   //************************************************************************
   // bus master currently driving the bus
   //************************************************************************
   typedef enum logic [1:0] {
      OWNER_CPU = 2'd0,                  // processor, default owner
      OWNER_RK  = 2'd1,                  // rk11 dma
      OWNER_MY  = 2'd2                   // my dma
   } bus_owner_e;

endpackage

/* dma_bus_arbiter.sv */
/*
 * bus master arbiter: fixed priority rk, my, cpu
 * owner moves only while no cycle is open; muxes master onto bus, routes ack back
 */
module dma_bus_arbiter import bus_pkg::*; (
   input  logic              wb_clk,
   input  logic              reset_i,
   // processor
   input  logic              cpu_cyc_i,
   input  logic              cpu_stb_i,
   input  logic              cpu_we_i,
   input  logic [ADDR_W-1:0] cpu_adr_i,
   input  logic [DATA_W-1:0] cpu_dat_i,
   input  logic [SEL_W-1:0]  cpu_sel_i,
   // rk11 dma
   input  logic              rk_dma_req_i,
   input  logic              rk_dma_stb_i,
   input  logic              rk_dma_we_i,
   input  logic [ADDR_W-1:0] rk_dma_adr_i,
   input  logic [DATA_W-1:0] rk_dma_dat_i,
   // my dma
   input  logic              my_dma_req_i,
   input  logic              my_dma_stb_i,
   input  logic              my_dma_we_i,
   input  logic [ADDR_W-1:0] my_dma_adr_i,
   input  logic [DATA_W-1:0] my_dma_dat_i,
   input  logic              bus_ack_i,       // combined slave ack
   output bus_owner_e        owner_o,
   // shared bus
   output logic              wb_cyc_o,
   output logic              wb_stb_o,
   output logic              wb_we_o,
   output logic [ADDR_W-1:0] wb_adr_o,
   output logic [DATA_W-1:0] wb_dat_o,
   output logic [SEL_W-1:0]  wb_sel_o,
   // grants and acks back to masters
   output logic              cpu_gnt_o,
   output logic              rk_dma_gnt_o,
   output logic              my_dma_gnt_o,
   output logic              cpu_ack_o,
   output logic              rk_dma_ack_o,
   output logic              my_dma_ack_o
);

   bus_owner_e owner_q;
   bus_owner_e owner_d;

   // next owner, looked at only with the bus idle
   always_comb begin
      owner_d = owner_q;
      if (!wb_cyc_o) begin
         if (rk_dma_req_i)
            owner_d = OWNER_RK;        // rk wins
         else if (my_dma_req_i)
            owner_d = OWNER_MY;
         else
            owner_d = OWNER_CPU;       // no dma, back to cpu
      end
   end

   always_ff @(posedge wb_clk) begin
      if (reset_i)
         owner_q <= OWNER_CPU;
      else
         owner_q <= owner_d;
   end

   //************************************************************************
   // master mux, dma cyc is its request and sel is always the whole word
   //************************************************************************
   always_comb begin
      case (owner_q)
         OWNER_RK: begin
            wb_cyc_o = rk_dma_req_i;
            wb_stb_o = rk_dma_stb_i;
            wb_we_o  = rk_dma_we_i;
            wb_adr_o = rk_dma_adr_i;
            wb_dat_o = rk_dma_dat_i;
            wb_sel_o = '1;
         end
         OWNER_MY: begin
            wb_cyc_o = my_dma_req_i;
            wb_stb_o = my_dma_stb_i;
            wb_we_o  = my_dma_we_i;
            wb_adr_o = my_dma_adr_i;
            wb_dat_o = my_dma_dat_i;
            wb_sel_o = '1;
         end
         default: begin
            wb_cyc_o = cpu_cyc_i;
            wb_stb_o = cpu_stb_i;
            wb_we_o  = cpu_we_i;
            wb_adr_o = cpu_adr_i;
            wb_dat_o = cpu_dat_i;
            wb_sel_o = cpu_sel_i;     // byte writes only from cpu
         end
      endcase
   end

   assign owner_o      = owner_q;
   assign cpu_gnt_o    = (owner_q == OWNER_CPU);
   assign rk_dma_gnt_o = (owner_q == OWNER_RK);
   assign my_dma_gnt_o = (owner_q == OWNER_MY);

   // ack goes to the owner only
   assign cpu_ack_o    = cpu_gnt_o & bus_ack_i;
   assign rk_dma_ack_o = rk_dma_gnt_o & bus_ack_i;
   assign my_dma_ack_o = my_dma_gnt_o & bus_ack_i;

   a_one_grant: assert property (@(posedge wb_clk) disable iff (reset_i)
      $onehot({cpu_gnt_o, rk_dma_gnt_o, my_dma_gnt_o}));

   // an open cycle pins the owner across the next edge
   a_owner_hold: assert property (@(posedge wb_clk) disable iff (reset_i)
      wb_cyc_o |=> $stable(owner_q));

endmodule

/* io_page_decoder.sv */
/*
 * i/o page decoder
 * one strobe per device from bus address, cyc and stb
 */
module io_page_decoder import bus_pkg::*; (
   input  logic [ADDR_W-1:0] wb_adr_i,
   input  logic              wb_cyc_i,
   input  logic              wb_stb_i,
   output logic              uart_stb_o,
   output logic              lpt_stb_o,
   output logic              rk_stb_o,
   output logic              dw_stb_o,
   output logic              my_stb_o
);

   logic bus_req;

   assign bus_req = wb_cyc_i & wb_stb_i;

   //************************************************************************
   // compare the address above each device span with its base
   //************************************************************************
   assign uart_stb_o = bus_req & ((wb_adr_i >> UART_SPAN) == (UART_BASE >> UART_SPAN)); // 177560-177566
   assign lpt_stb_o  = bus_req & ((wb_adr_i >> LPT_SPAN) == (LPT_BASE >> LPT_SPAN));    // 177514-177516
   assign rk_stb_o   = bus_req & ((wb_adr_i >> RK_SPAN) == (RK_BASE >> RK_SPAN));       // 177400-177416
   assign dw_stb_o   = bus_req & ((wb_adr_i >> DW_SPAN) == (DW_BASE >> DW_SPAN));       // 174000-174036
   assign my_stb_o   = bus_req & ((wb_adr_i >> MY_SPAN) == (MY_BASE >> MY_SPAN));       // 172140-172142

   // the device windows in the package must not overlap
   always_comb begin
      a_one_strobe: assert ($onehot0({uart_stb_o, lpt_stb_o, rk_stb_o, dw_stb_o, my_stb_o}));
   end

endmodule

/* memory_window.sv */
/*
 * memory window: ram below 140000, user rom 140000-157777
 * sdram requests and byte masks, ram and rom ack timing
 */
module memory_window import bus_pkg::*; (
   input  logic                wb_clk,
   input  logic                reset_i,
   input  logic [ADDR_W-1:0]   wb_adr_i,
   input  logic                wb_cyc_i,
   input  logic                wb_stb_i,
   input  logic                wb_we_i,
   input  logic [SEL_W-1:0]    wb_sel_i,
   input  logic                sdram_wr_ack_i,
   input  logic                sdram_rd_ack_i,
   output logic                ram_sel_o,
   output logic                rom_sel_o,
   output logic                sdram_wr_req_o,
   output logic                sdram_rd_req_o,
   output logic [SDRAM_AW-1:0] sdram_addr_o,
   output logic [SEL_W-1:0]    sdram_dqm_o,
   output logic                ram_ack_o,
   output logic                rom_ack_o,
   output logic [ROM_AW-1:0]   rom_addr_o
);

   logic                 bus_req;
   logic                 ram_hold;      // ram strobe held, not yet acked
   logic                 rom_hold;      // rom read held, not yet acked
   logic [ACK_DELAY-1:0] ram_ack_sr;
   logic [1:0]           rom_ack_sr;

   assign bus_req   = wb_cyc_i & wb_stb_i;
   assign ram_sel_o = bus_req & (wb_adr_i < ROM_BASE);
   assign rom_sel_o = bus_req & (wb_adr_i >= ROM_BASE) & (wb_adr_i < IO_PAGE_BASE);

   // sdram side
   assign sdram_wr_req_o = ram_sel_o & wb_we_i;
   assign sdram_rd_req_o = ram_sel_o & ~wb_we_i;
   assign sdram_addr_o   = wb_adr_i[ADDR_W-1:1];        // byte -> word address
   assign sdram_dqm_o    = wb_we_i ? ~wb_sel_i : '0;    // reads always whole word
   assign rom_addr_o     = wb_adr_i[ROM_AW:1];

   //************************************************************************
   // ack shaping
   //************************************************************************
   assign ram_hold = ram_sel_o & ~ram_ack_o;
   assign rom_hold = rom_sel_o & ~wb_we_i & ~rom_ack_o;  // rom writes never acked

   always_ff @(posedge wb_clk) begin
      if (reset_i) begin
         ram_ack_sr <= '0;
         rom_ack_sr <= '0;
      end else begin
         ram_ack_sr[0] <= ram_hold & (sdram_wr_ack_i | sdram_rd_ack_i);
         for (int i = 1; i < ACK_DELAY; i++)
            ram_ack_sr[i] <= ram_hold & ram_ack_sr[i-1];   // drops if strobe goes away
         rom_ack_sr[0] <= rom_hold;
         rom_ack_sr[1] <= rom_hold & rom_ack_sr[0];
      end
   end

   assign ram_ack_o = ram_sel_o & ram_ack_sr[ACK_DELAY-1];
   assign rom_ack_o = rom_sel_o & ~wb_we_i & rom_ack_sr[1];   // 2 clocks after strobe

   a_one_window: assert property (@(posedge wb_clk) disable iff (reset_i)
      !(ram_sel_o && rom_sel_o));

endmodule

/* bus_response_mux.sv */
/*
 * response combiner: or of all slave acks
 * read data or-ed per slave, gated by its select
 */
module bus_response_mux import bus_pkg::*; (
   input  logic              ram_sel_i,
   input  logic              rom_sel_i,
   input  logic              ram_ack_i,
   input  logic              rom_ack_i,
   input  logic [DATA_W-1:0] ram_dat_i,
   input  logic [DATA_W-1:0] rom_dat_i,
   input  logic              uart_stb_i,
   input  logic              lpt_stb_i,
   input  logic              rk_stb_i,
   input  logic              dw_stb_i,
   input  logic              my_stb_i,
   input  logic              uart_ack_i,
   input  logic              lpt_ack_i,
   input  logic              rk_ack_i,
   input  logic              dw_ack_i,
   input  logic              my_ack_i,
   input  logic [DATA_W-1:0] uart_dat_i,
   input  logic [DATA_W-1:0] lpt_dat_i,
   input  logic [DATA_W-1:0] rk_dat_i,
   input  logic [DATA_W-1:0] dw_dat_i,
   input  logic [DATA_W-1:0] my_dat_i,
   output logic              bus_ack_o,
   output logic [DATA_W-1:0] rd_dat_o
);

   // any slave may finish the cycle
   assign bus_ack_o = ram_ack_i | rom_ack_i | uart_ack_i | lpt_ack_i
                    | rk_ack_i | dw_ack_i | my_ack_i;

   // unselected slaves read as zero
   assign rd_dat_o = ({DATA_W{ram_sel_i}}  & ram_dat_i)
                   | ({DATA_W{rom_sel_i}}  & rom_dat_i)
                   | ({DATA_W{uart_stb_i}} & uart_dat_i)
                   | ({DATA_W{lpt_stb_i}}  & lpt_dat_i)
                   | ({DATA_W{rk_stb_i}}   & rk_dat_i)
                   | ({DATA_W{dw_stb_i}}   & dw_dat_i)
                   | ({DATA_W{my_stb_i}}   & my_dat_i);

endmodule

/* wb_backplane.sv */
/*
 * backplane core: arbiter, memory window, i/o page decoder, response combiner
 */
module wb_backplane import bus_pkg::*; (
   input  logic                wb_clk,
   input  logic                reset_i,
   // masters
   input  logic                cpu_cyc_i,
   input  logic                cpu_stb_i,
   input  logic                cpu_we_i,
   input  logic [ADDR_W-1:0]   cpu_adr_i,
   input  logic [DATA_W-1:0]   cpu_dat_i,
   input  logic [SEL_W-1:0]    cpu_sel_i,
   input  logic                rk_dma_req_i,
   input  logic                rk_dma_stb_i,
   input  logic                rk_dma_we_i,
   input  logic [ADDR_W-1:0]   rk_dma_adr_i,
   input  logic [DATA_W-1:0]   rk_dma_dat_i,
   input  logic                my_dma_req_i,
   input  logic                my_dma_stb_i,
   input  logic                my_dma_we_i,
   input  logic [ADDR_W-1:0]   my_dma_adr_i,
   input  logic [DATA_W-1:0]   my_dma_dat_i,
   output bus_owner_e          owner_o,
   output logic                cpu_gnt_o,
   output logic                rk_dma_gnt_o,
   output logic                my_dma_gnt_o,
   output logic                cpu_ack_o,
   output logic                rk_dma_ack_o,
   output logic                my_dma_ack_o,
   // shared bus toward slaves
   output logic [ADDR_W-1:0]   wb_adr_o,
   output logic [DATA_W-1:0]   wb_dat_o,
   output logic                wb_we_o,
   output logic [SEL_W-1:0]    wb_sel_o,
   output logic [DATA_W-1:0]   rd_dat_o,     // read data to all masters
   // i/o page devices
   output logic                uart_stb_o,
   output logic                lpt_stb_o,
   output logic                rk_stb_o,
   output logic                dw_stb_o,
   output logic                my_stb_o,
   input  logic                uart_ack_i,
   input  logic                lpt_ack_i,
   input  logic                rk_ack_i,
   input  logic                dw_ack_i,
   input  logic                my_ack_i,
   input  logic [DATA_W-1:0]   uart_dat_i,
   input  logic [DATA_W-1:0]   lpt_dat_i,
   input  logic [DATA_W-1:0]   rk_dat_i,
   input  logic [DATA_W-1:0]   dw_dat_i,
   input  logic [DATA_W-1:0]   my_dat_i,
   // sdram and rom
   output logic                sdram_wr_req_o,
   output logic                sdram_rd_req_o,
   output logic [SDRAM_AW-1:0] sdram_addr_o,
   output logic [SEL_W-1:0]    sdram_dqm_o,
   input  logic                sdram_wr_ack_i,
   input  logic                sdram_rd_ack_i,
   output logic [ROM_AW-1:0]   rom_addr_o,
   input  logic [DATA_W-1:0]   ram_dat_i,
   input  logic [DATA_W-1:0]   rom_dat_i
);

   logic wb_cyc;
   logic wb_stb;
   logic bus_ack;       // or of all slave acks
   logic ram_sel;
   logic rom_sel;
   logic ram_ack;
   logic rom_ack;

   //************************************************************************
   // bus master side
   //************************************************************************
   dma_bus_arbiter u_arbiter (
      .wb_clk       (wb_clk),
      .reset_i      (reset_i),
      .cpu_cyc_i    (cpu_cyc_i),
      .cpu_stb_i    (cpu_stb_i),
      .cpu_we_i     (cpu_we_i),
      .cpu_adr_i    (cpu_adr_i),
      .cpu_dat_i    (cpu_dat_i),
      .cpu_sel_i    (cpu_sel_i),
      .rk_dma_req_i (rk_dma_req_i),
      .rk_dma_stb_i (rk_dma_stb_i),
      .rk_dma_we_i  (rk_dma_we_i),
      .rk_dma_adr_i (rk_dma_adr_i),
      .rk_dma_dat_i (rk_dma_dat_i),
      .my_dma_req_i (my_dma_req_i),
      .my_dma_stb_i (my_dma_stb_i),
      .my_dma_we_i  (my_dma_we_i),
      .my_dma_adr_i (my_dma_adr_i),
      .my_dma_dat_i (my_dma_dat_i),
      .bus_ack_i    (bus_ack),
      .owner_o      (owner_o),
      .wb_cyc_o     (wb_cyc),
      .wb_stb_o     (wb_stb),
      .wb_we_o      (wb_we_o),
      .wb_adr_o     (wb_adr_o),
      .wb_dat_o     (wb_dat_o),
      .wb_sel_o     (wb_sel_o),
      .cpu_gnt_o    (cpu_gnt_o),
      .rk_dma_gnt_o (rk_dma_gnt_o),
      .my_dma_gnt_o (my_dma_gnt_o),
      .cpu_ack_o    (cpu_ack_o),
      .rk_dma_ack_o (rk_dma_ack_o),
      .my_dma_ack_o (my_dma_ack_o)
   );

   //************************************************************************
   // address map, both halves look at the same bus
   //************************************************************************
   memory_window u_mem_window (
      .wb_clk         (wb_clk),
      .reset_i        (reset_i),
      .wb_adr_i       (wb_adr_o),
      .wb_cyc_i       (wb_cyc),
      .wb_stb_i       (wb_stb),
      .wb_we_i        (wb_we_o),
      .wb_sel_i       (wb_sel_o),
      .sdram_wr_ack_i (sdram_wr_ack_i),
      .sdram_rd_ack_i (sdram_rd_ack_i),
      .ram_sel_o      (ram_sel),
      .rom_sel_o      (rom_sel),
      .sdram_wr_req_o (sdram_wr_req_o),
      .sdram_rd_req_o (sdram_rd_req_o),
      .sdram_addr_o   (sdram_addr_o),
      .sdram_dqm_o    (sdram_dqm_o),
      .ram_ack_o      (ram_ack),
      .rom_ack_o      (rom_ack),
      .rom_addr_o     (rom_addr_o)
   );

   io_page_decoder u_io_decoder (
      .wb_adr_i   (wb_adr_o),
      .wb_cyc_i   (wb_cyc),
      .wb_stb_i   (wb_stb),
      .uart_stb_o (uart_stb_o),
      .lpt_stb_o  (lpt_stb_o),
      .rk_stb_o   (rk_stb_o),
      .dw_stb_o   (dw_stb_o),
      .my_stb_o   (my_stb_o)
   );

   // response path back to the arbiter
   bus_response_mux u_resp_mux (
      .ram_sel_i  (ram_sel),
      .rom_sel_i  (rom_sel),
      .ram_ack_i  (ram_ack),
      .rom_ack_i  (rom_ack),
      .ram_dat_i  (ram_dat_i),
      .rom_dat_i  (rom_dat_i),
      .uart_stb_i (uart_stb_o),
      .lpt_stb_i  (lpt_stb_o),
      .rk_stb_i   (rk_stb_o),
      .dw_stb_i   (dw_stb_o),
      .my_stb_i   (my_stb_o),
      .uart_ack_i (uart_ack_i),
      .lpt_ack_i  (lpt_ack_i),
      .rk_ack_i   (rk_ack_i),
      .dw_ack_i   (dw_ack_i),
      .my_ack_i   (my_ack_i),
      .uart_dat_i (uart_dat_i),
      .lpt_dat_i  (lpt_dat_i),
      .rk_dat_i   (rk_dat_i),
      .dw_dat_i   (dw_dat_i),
      .my_dat_i   (my_dat_i),
      .bus_ack_o  (bus_ack),
      .rd_dat_o   (rd_dat_o)
   );

endmodule

/* tb_clock_gen.sv */
/*
 * testbench clock and reset
 * 4 ns wb_clk, reset held high for the first 2 cycles
 */
module tb_clock_gen (
   output logic wb_clk,
   output logic reset_o
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      wb_clk = 1'b0;
      forever #2 wb_clk = ~wb_clk;      // 4 ns period
   end

   initial begin
      reset_o = 1'b1;
      repeat (2) @(posedge wb_clk);
      @(negedge wb_clk);
      reset_o = 1'b0;                   // released away from the sampling edge
   end

endmodule

/* tb_backplane.sv */
/*
 * testbench for the backplane core
 * cpu and dma masters, rom/ram/device slave models, assertion checks
 */
module tb_backplane import bus_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int MAX_CYCLES = 400;   // about 200 cycles of tests plus margin

   logic wb_clk, reset_i;
   logic cpu_cyc_i, cpu_stb_i, cpu_we_i;
   logic [15:0] cpu_adr_i, cpu_dat_i;
   logic [1:0] cpu_sel_i;
   logic rk_dma_req_i, rk_dma_stb_i, rk_dma_we_i, my_dma_req_i, my_dma_stb_i, my_dma_we_i;
   logic [15:0] rk_dma_adr_i, rk_dma_dat_i, my_dma_adr_i, my_dma_dat_i;
   bus_owner_e owner_o;
   logic cpu_gnt_o, rk_dma_gnt_o, my_dma_gnt_o, cpu_ack_o, rk_dma_ack_o, my_dma_ack_o;
   logic [15:0] wb_adr_o, wb_dat_o, rd_dat_o;
   logic wb_we_o;
   logic [1:0] wb_sel_o;
   logic uart_stb_o, lpt_stb_o, rk_stb_o, dw_stb_o, my_stb_o;
   logic sdram_wr_req_o, sdram_rd_req_o;
   logic [14:0] sdram_addr_o;
   logic [1:0] sdram_dqm_o;
   logic [11:0] rom_addr_o;
   logic [15:0] mem [0:32767];        // sdram model contents

   logic [31:0] lfsr;
   int cyc_cnt, ref_cyc, exp_lat, active, errors;
   logic [15:0] exp_dat;
   logic [14:0] exp_word;
   logic [1:0] exp_dqm;
   logic [4:0] exp_strb, dev_seen, dev_ack, dev_stb;
   logic exp_we, quiet, cpu_ack_q, rk_ack_q, my_ack_q;
   logic ram_ack, ram_req_q;
   int ram_state, ram_wait;
   logic [15:0] merged [0:3];
   logic [15:0] dev_base [0:4];
   int dev_span [0:4];
   logic any_ack, bus_idle;

   tb_clock_gen u_clk (.wb_clk(wb_clk), .reset_o(reset_i));

   wb_backplane dut (.*,
      .uart_ack_i(dev_ack[4]), .lpt_ack_i(dev_ack[3]), .rk_ack_i(dev_ack[2]),
      .dw_ack_i(dev_ack[1]), .my_ack_i(dev_ack[0]),
      .uart_dat_i(UART_BASE ^ wb_adr_o), .lpt_dat_i(LPT_BASE ^ wb_adr_o),
      .rk_dat_i(RK_BASE ^ wb_adr_o), .dw_dat_i(DW_BASE ^ wb_adr_o),
      .my_dat_i(MY_BASE ^ wb_adr_o),
      .sdram_wr_ack_i(ram_ack & wb_we_o), .sdram_rd_ack_i(ram_ack & ~wb_we_o),
      .ram_dat_i(mem[sdram_addr_o]),
      .rom_dat_i({4'b0, rom_addr_o} ^ 16'o052525));   // rom rule on word address

   assign dev_stb  = {uart_stb_o, lpt_stb_o, rk_stb_o, dw_stb_o, my_stb_o};
   assign any_ack  = cpu_ack_o | rk_dma_ack_o | my_dma_ack_o;
   assign bus_idle = cpu_gnt_o ? !cpu_cyc_i : rk_dma_gnt_o ? !rk_dma_req_i : !my_dma_req_i;

   // Fibonacci lfsr with taps 32 22 2 1 stepped once per bit
   task automatic rand_bits(input int n, output logic [15:0] v);
      logic fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[14:0], fb};
      end
   endtask

   function automatic logic [15:0] fill_word(input logic [14:0] a);
      return ({a, 1'b1} * 16'h9e37) ^ {a[6:0], a[14:6]};
   endfunction

   function automatic logic [15:0] merge(input logic [15:0] old, input logic [15:0] nw,
                                          input logic [1:0] sel);
      return {sel[1] ? nw[15:8] : old[15:8], sel[0] ? nw[7:0] : old[7:0]};
   endfunction

   //************************************************************************
   // slave models sample on rise and answer on fall
   //************************************************************************
   always @(posedge wb_clk) begin
      cyc_cnt   <= cyc_cnt + 1;
      dev_seen  <= dev_stb;
      ram_req_q <= sdram_wr_req_o | sdram_rd_req_o;
      cpu_ack_q <= cpu_ack_o;
      rk_ack_q  <= rk_dma_ack_o;
      my_ack_q  <= my_dma_ack_o;
      if (cyc_cnt >= MAX_CYCLES) begin
         $display("timeout: run went past %0d cycles without finishing", MAX_CYCLES);
         $display("tests failed");
         $finish;
      end
   end

   always @(negedge wb_clk) begin
      logic [15:0] r;
      if (|(dev_seen & ~dev_ack))
         ref_cyc = cyc_cnt;            // device ack starts the count
      dev_ack = dev_seen & ~dev_ack;   // one pulse per strobe
      ram_ack = 1'b0;
      case (ram_state)
         0: if (ram_req_q) begin
            rand_bits(2, r);
            ram_wait  = r + 1;         // 1 to 4 cycles
            ram_state = 1;
         end
         1: begin
            ram_wait--;
            if (ram_wait == 0) begin
               ram_ack = 1'b1;
               ref_cyc = cyc_cnt;
               for (int b = 0; b < 2; b++)
                  if (sdram_wr_req_o && !sdram_dqm_o[b])
                     mem[sdram_addr_o][8*b +: 8] = wb_dat_o[8*b +: 8];
               ram_state = 2;
            end
         end
         default: if (!ram_req_q) ram_state = 0;   // wait for the request to drop
      endcase
   end

   //************************************************************************
   // checks
   //************************************************************************
   a_ack_owner: assert property (@(posedge wb_clk) disable iff (reset_i)
      !((cpu_ack_o && active != 0) || (rk_dma_ack_o && active != 1)
        || (my_dma_ack_o && active != 2)))
   else begin
      errors++;
      $display("Mismatch at %0t: ack to a master not on the bus", $time);
   end
   a_ack_data: assert property (@(posedge wb_clk) disable iff (reset_i)
      any_ack && !exp_we |-> rd_dat_o == exp_dat)
   else begin
      errors++;
      $display("Mismatch at %0t: read data %h, expected %h", $time, rd_dat_o, exp_dat);
   end
   a_ack_lat: assert property (@(posedge wb_clk) disable iff (reset_i)
      any_ack |-> (cyc_cnt - ref_cyc) == exp_lat)
   else begin
      errors++;
      $display("Mismatch at %0t: ack after %0d cycles, expected %0d",
               $time, cyc_cnt - ref_cyc, exp_lat);
   end
   a_no_ack: assert property (@(posedge wb_clk) disable iff (reset_i) quiet |-> !any_ack)
   else begin
      errors++;
      $display("Mismatch at %0t: unmapped address acked", $time);
   end
   a_strobe: assert property (@(posedge wb_clk) disable iff (reset_i)
      cpu_gnt_o && cpu_stb_i |-> dev_stb == exp_strb)
   else begin
      errors++;
      $display("Mismatch at %0t: strobes %b, expected %b", $time, dev_stb, exp_strb);
   end
   a_sdram: assert property (@(posedge wb_clk) disable iff (reset_i)
      sdram_wr_req_o || sdram_rd_req_o |-> sdram_addr_o == exp_word && sdram_dqm_o == exp_dqm)
   else begin
      errors++;
      $display("Mismatch at %0t: sdram addr %h dqm %b", $time, sdram_addr_o, sdram_dqm_o);
   end
   a_rk_bus: assert property (@(posedge wb_clk) disable iff (reset_i)
      rk_dma_gnt_o && rk_dma_req_i |-> wb_adr_o == rk_dma_adr_i && wb_sel_o == 2'b11)
   else begin
      errors++;
      $display("Mismatch at %0t: rk bus adr %h sel %b", $time, wb_adr_o, wb_sel_o);
   end
   a_my_bus: assert property (@(posedge wb_clk) disable iff (reset_i)
      my_dma_gnt_o && my_dma_req_i |-> wb_adr_o == my_dma_adr_i && wb_sel_o == 2'b11)
   else begin
      errors++;
      $display("Mismatch at %0t: my bus adr %h sel %b", $time, wb_adr_o, wb_sel_o);
   end
   a_arb_rk: assert property (@(posedge wb_clk) disable iff (reset_i)
      rk_dma_req_i && bus_idle |=> rk_dma_gnt_o && !cpu_gnt_o && !my_dma_gnt_o
                                   && owner_o == OWNER_RK)
   else begin
      errors++;
      $display("Mismatch at %0t: rk not granted, owner %0d", $time, owner_o);
   end
   a_arb_my: assert property (@(posedge wb_clk) disable iff (reset_i)
      my_dma_req_i && !rk_dma_req_i && bus_idle |=> my_dma_gnt_o && !cpu_gnt_o
                                                    && owner_o == OWNER_MY)
   else begin
      errors++;
      $display("Mismatch at %0t: my not granted, owner %0d", $time, owner_o);
   end
   a_arb_cpu: assert property (@(posedge wb_clk) disable iff (reset_i)
      !rk_dma_req_i && !my_dma_req_i && bus_idle |=> cpu_gnt_o && owner_o == OWNER_CPU)
   else begin
      errors++;
      $display("Mismatch at %0t: bus not back at cpu, owner %0d", $time, owner_o);
   end
   a_arb_hold: assert property (@(posedge wb_clk) disable iff (reset_i)
      !bus_idle |=> $stable({cpu_gnt_o, rk_dma_gnt_o, my_dma_gnt_o}))
   else begin
      errors++;
      $display("Mismatch at %0t: grant moved in open cycle", $time);
   end

   //************************************************************************
   // masters
   //************************************************************************
   task automatic set_expect(input int who, input logic [15:0] adr, input logic we,
                             input logic [1:0] sel, input logic [15:0] exp, input int lat);
      active   = who;
      exp_we   = we;
      exp_dat  = exp;
      exp_lat  = lat;
      ref_cyc  = cyc_cnt;                // rom counts from the strobe
      exp_word = adr[15:1];
      exp_dqm  = we ? ~sel : 2'b00;
   endtask

   task automatic wait_ack(input int who);
      do @(negedge wb_clk);
      while (!(who == 0 ? cpu_ack_q : who == 1 ? rk_ack_q : my_ack_q));
   endtask

   task automatic cpu_access(input logic [15:0] adr, input logic we, input logic [15:0] dat,
                             input logic [1:0] sel, input logic [15:0] exp, input int lat);
      @(negedge wb_clk);
      set_expect(0, adr, we, sel, exp, lat);
      cpu_adr_i = adr;
      cpu_we_i  = we;
      cpu_dat_i = dat;
      cpu_sel_i = sel;
      cpu_cyc_i = 1'b1;
      cpu_stb_i = 1'b1;
      wait_ack(0);
      cpu_cyc_i = 1'b0;
      cpu_stb_i = 1'b0;
   endtask

   initial begin
      logic [15:0] r, adr;
      {cpu_cyc_i, cpu_stb_i, cpu_we_i, cpu_adr_i, cpu_dat_i} = '0;
      cpu_sel_i = 2'b11;
      {rk_dma_req_i, rk_dma_stb_i, rk_dma_we_i, rk_dma_adr_i, rk_dma_dat_i} = '0;
      {my_dma_req_i, my_dma_stb_i, my_dma_we_i, my_dma_adr_i, my_dma_dat_i} = '0;
      lfsr = 32'h7c1096a0;
      {cyc_cnt, ref_cyc, exp_lat, active, errors, ram_state, ram_wait} = '0;
      {exp_dat, exp_word, exp_dqm, exp_strb, exp_we, quiet} = '0;
      {dev_ack, ram_ack} = '0;
      dev_base = '{UART_BASE, LPT_BASE, RK_BASE, DW_BASE, MY_BASE};
      dev_span = '{UART_SPAN, LPT_SPAN, RK_SPAN, DW_SPAN, MY_SPAN};
      for (int i = 0; i < 32768; i++)
         mem[i] = fill_word(i[14:0]);
      do @(negedge wb_clk);
      while (reset_i);

      // rom reads of random words and the last one
      for (int k = 0; k < 5; k++) begin
         rand_bits(12, r);
         adr = (k == 4) ? 16'o157776 : ROM_BASE + {r[11:0], 1'b0};
         cpu_access(adr, 1'b0, '0, 2'b11, {4'b0, adr[12:1]} ^ 16'o052525, 2);
      end

      // ram byte writes with every sel and then merged read back
      for (int s = 0; s < 4; s++) begin
         rand_bits(16, r);
         adr = 16'o001000 + 16'(2 * s);
         cpu_access(adr, 1'b1, r, 2'(s), '0, ACK_DELAY);
         merged[s] = merge(fill_word(adr[15:1]), r, 2'(s));
      end
      for (int s = 0; s < 4; s++)
         cpu_access(16'o001000 + 16'(2 * s), 1'b0, '0, 2'b11, merged[s], ACK_DELAY);

      // every device at its base and last word
      for (int d = 0; d < 5; d++) begin
         for (int l = 0; l < 2; l++) begin
            adr = dev_base[d] + (l == 1 ? (16'd1 << dev_span[d]) - 16'd2 : 16'd0);
            exp_strb = 5'b10000 >> d;
            cpu_access(adr, 1'b0, '0, 2'b11, dev_base[d] ^ adr, 0);
         end
      end
      exp_strb = '0;

      // unmapped i/o word stays silent
      @(negedge wb_clk);
      quiet     = 1'b1;
      active    = 0;
      cpu_adr_i = 16'o177000;
      cpu_we_i  = 1'b0;
      cpu_cyc_i = 1'b1;
      cpu_stb_i = 1'b1;
      repeat (10) @(negedge wb_clk);
      {cpu_cyc_i, cpu_stb_i, quiet} = '0;

      // rk alone and then rk and my together
      @(negedge wb_clk);
      cpu_sel_i = 2'b00;                 // dma sel must come out as both bytes
      set_expect(1, 16'o001000, 1'b0, 2'b11, merged[0], ACK_DELAY);
      {rk_dma_req_i, rk_dma_stb_i, rk_dma_adr_i} = {2'b11, 16'o001000};
      wait_ack(1);
      {rk_dma_req_i, rk_dma_stb_i} = '0;
      @(negedge wb_clk);
      set_expect(1, 16'o001002, 1'b0, 2'b11, merged[1], ACK_DELAY);
      {rk_dma_req_i, rk_dma_stb_i, rk_dma_adr_i} = {2'b11, 16'o001002};
      {my_dma_req_i, my_dma_stb_i, my_dma_adr_i} = {2'b11, 16'o001004};
      wait_ack(1);
      {rk_dma_req_i, rk_dma_stb_i} = '0;
      set_expect(2, 16'o001004, 1'b0, 2'b11, merged[2], ACK_DELAY);
      wait_ack(2);
      {my_dma_req_i, my_dma_stb_i} = '0;

      // rk request during an open cpu rom read waits for its end
      @(negedge wb_clk);
      set_expect(0, 16'o140100, 1'b0, 2'b11, 16'o000040 ^ 16'o052525, 2);
      {cpu_adr_i, cpu_cyc_i, cpu_stb_i} = {16'o140100, 2'b11};
      @(negedge wb_clk);
      {rk_dma_req_i, rk_dma_stb_i, rk_dma_adr_i} = {2'b11, 16'o001006};
      wait_ack(0);
      {cpu_cyc_i, cpu_stb_i} = '0;
      set_expect(1, 16'o001006, 1'b0, 2'b11, merged[3], ACK_DELAY);
      wait_ack(1);
      {rk_dma_req_i, rk_dma_stb_i} = '0;

      repeat (3) @(negedge wb_clk);
      $display("summary: %0d errors after %0d cycles", errors, cyc_cnt);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

/* vlog.f */
bus_pkg.sv
dma_bus_arbiter.sv
io_page_decoder.sv
memory_window.sv
bus_response_mux.sv
wb_backplane.sv
tb_clock_gen.sv
tb_backplane.sv

/* run_sim.sh */
#!/bin/sh
# build and run the backplane testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_backplane \
   -f vlog.f -o tb_backplane > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed"
   exit 1
fi

./obj_dir/tb_backplane > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulator exited with status $status"
   exit 1
fi

if grep -q "tests failed" sim.log; then
   exit 1
fi
exit 0
